// ==== hw/led_matrix_macros.svh ====
`ifndef LED_MATRIX_MACROS_SVH
`define LED_MATRIX_MACROS_SVH

// Panel geometry, 8x8 for simulation
`define LM_WIDTH 8
`define LM_HEIGHT 8
`define LM_ADDR_W 6     // log2(LM_WIDTH * LM_HEIGHT)
`define LM_COL_W 3      // log2(LM_WIDTH)
`define LM_ROW_W 2      // log2(LM_HEIGHT / 2), one address drives both halves

// Serial bit time in clk_root cycles
`define LM_UART_TICKS 8

// Binary-coded modulation
`define LM_PLANES 6
`define LM_OE_UNIT 4    // Lit cycles of plane 0

`endif

// ==== hw/led_matrix_pkg.sv ====
`include "led_matrix_macros.svh"

package led_matrix_pkg;

    // Standard RGB565 layout, red in the top bits
    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    typedef struct packed {
        logic [`LM_ADDR_W-1:0] addr;
        rgb565_t               data;
    } fb_write_t;

    typedef struct packed {
        rgb565_t top;
        rgb565_t bottom;
    } pixel_pair_t;

    // rgb bit 0 is red, bit 1 green, bit 2 blue
    typedef struct packed {
        logic [2:0]           rgb_top;
        logic [2:0]           rgb_bottom;
        logic [`LM_ROW_W-1:0] row_addr;
        logic                 clk_pixel;
        logic                 row_latch;
        logic                 oe_n;
    } panel_pins_t;

endpackage

// ==== hw/uart_byte_rx.sv ====
`include "led_matrix_macros.svh"

module uart_byte_rx (
    input  logic       clk_root,
    input  logic       rst_n,
    input  logic       uart_rx,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);
    localparam int TICK_W = $clog2(`LM_UART_TICKS);

    typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} rx_state_t;

    rx_state_t         state;
    logic [1:0]        rx_sync;
    logic              rx_line;
    logic [TICK_W-1:0] tick_cnt;
    logic [2:0]        bit_cnt;
    logic [7:0]        shift;

    // Two-flop synchronizer, idles high
    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            rx_sync <= 2'b11;
        end else begin
            rx_sync <= {rx_sync[0], uart_rx};
        end
    end

    assign rx_line = rx_sync[1];

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (!rx_line) begin
                        state    <= S_START;
                        tick_cnt <= TICK_W'(`LM_UART_TICKS / 2 - 1); // Half a bit to centre
                    end
                end
                S_START: begin
                    if (tick_cnt != '0) begin
                        tick_cnt <= tick_cnt - 1'b1;
                    end else if (!rx_line) begin
                        state    <= S_DATA;
                        tick_cnt <= TICK_W'(`LM_UART_TICKS - 1);
                        bit_cnt  <= '0;
                    end else begin
                        state <= S_IDLE; // Glitch, not a start bit
                    end
                end
                S_DATA: begin
                    if (tick_cnt != '0) begin
                        tick_cnt <= tick_cnt - 1'b1;
                    end else begin
                        tick_cnt <= TICK_W'(`LM_UART_TICKS - 1);
                        if (bit_cnt == 3'd7) begin
                            state <= S_STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                S_STOP: begin
                    if (tick_cnt != '0) begin
                        tick_cnt <= tick_cnt - 1'b1;
                    end else begin
                        state    <= S_IDLE;
                        rx_valid <= rx_line; // Bad stop bit drops the byte
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // LSB first
    always_ff @(posedge clk_root) begin
        if (state == S_DATA && tick_cnt == '0) begin
            shift <= {rx_line, shift[7:1]};
        end
    end

    assign rx_byte = shift;

endmodule

// ==== hw/frame_loader.sv ====
`include "led_matrix_macros.svh"

module frame_loader (
    input  logic                      clk_root,
    input  logic                      rst_n,
    input  logic [7:0]                rx_byte,
    input  logic                      rx_valid,
    output led_matrix_pkg::fb_write_t wr,
    output logic                      wr_valid,
    output logic [2:0]                rgb_enable,
    output logic [`LM_PLANES-1:0]     plane_enable
);
    import led_matrix_pkg::*;

    localparam int ADDR_W = `LM_ADDR_W;
    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(`LM_WIDTH * `LM_HEIGHT - 1);

    typedef enum logic [2:0] {S_CMD, S_LO, S_HI, S_RGB, S_PLANE} ld_state_t;

    ld_state_t         state;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        lo_byte;

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            state        <= S_CMD;
            addr         <= '0;
            wr_valid     <= 1'b0;
            rgb_enable   <= '1;
            plane_enable <= '1;
        end else begin
            wr_valid <= 1'b0;
            if (rx_valid) begin
                case (state)
                    S_CMD: begin
                        addr <= '0;
                        case (rx_byte)
                            "L":     state <= S_LO;
                            "E":     state <= S_RGB;
                            "M":     state <= S_PLANE;
                            default: state <= S_CMD; // Unknown command
                        endcase
                    end
                    S_LO: state <= S_HI;
                    S_HI: begin
                        wr_valid <= 1'b1;
                        addr     <= addr + 1'b1;
                        state    <= (addr == LAST_ADDR) ? S_CMD : S_LO;
                    end
                    S_RGB: begin
                        rgb_enable <= rx_byte[2:0];
                        state      <= S_CMD;
                    end
                    S_PLANE: begin
                        plane_enable <= rx_byte[`LM_PLANES-1:0];
                        state        <= S_CMD;
                    end
                    default: state <= S_CMD;
                endcase
            end
        end
    end

    // Pixel assembly, low byte arrives first
    always_ff @(posedge clk_root) begin
        if (rx_valid && state == S_LO) begin
            lo_byte <= rx_byte;
        end
        if (rx_valid && state == S_HI) begin
            wr.addr <= addr;
            wr.data <= rgb565_t'({rx_byte, lo_byte});
        end
    end

endmodule

// ==== hw/frame_buffer.sv ====
`include "led_matrix_macros.svh"

module frame_buffer (
    input  logic                      clk_root,
    input  led_matrix_pkg::fb_write_t wr,
    input  logic                      wr_valid,
    input  logic [`LM_ADDR_W-1:0]     rd_addr,
    input  logic                      rd_en,
    output led_matrix_pkg::rgb565_t   rd_data
);
    import led_matrix_pkg::*;

    localparam int DEPTH = `LM_WIDTH * `LM_HEIGHT;

    // One RGB565 word per pixel, raster order
    rgb565_t mem [DEPTH];

    // Port A, loader side
    always_ff @(posedge clk_root) begin
        if (wr_valid) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Port B, fetch side with one cycle of latency
    always_ff @(posedge clk_root) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== hw/framebuffer_fetch.sv ====
`include "led_matrix_macros.svh"

module framebuffer_fetch (
    input  logic                        clk_root,
    input  logic                        rst_n,
    input  logic                        row_req_valid,
    input  logic [`LM_ROW_W-1:0]        row_req_index,
    output logic                        row_req_ready,
    output led_matrix_pkg::pixel_pair_t pair,
    output logic                        pair_valid,
    input  logic                        pair_ready,
    output logic [`LM_ADDR_W-1:0]       rd_addr,
    output logic                        rd_en,
    input  led_matrix_pkg::rgb565_t     rd_data
);
    localparam int ADDR_W = `LM_ADDR_W;
    localparam int COL_W  = `LM_COL_W;

    typedef enum logic [2:0] {S_IDLE, S_TOP, S_BOT, S_CAP, S_HOLD} fetch_state_t;

    fetch_state_t         state;
    logic [`LM_ROW_W-1:0] row_q;
    logic [COL_W-1:0]     col;
    logic [ADDR_W-1:0]    top_addr;
    logic [ADDR_W-1:0]    bot_addr;

    assign top_addr = ADDR_W'(int'(row_q) * `LM_WIDTH + int'(col));
    assign bot_addr = ADDR_W'((int'(row_q) + `LM_HEIGHT / 2) * `LM_WIDTH + int'(col));

    assign row_req_ready = (state == S_IDLE);
    assign pair_valid    = (state == S_HOLD);
    assign rd_en         = (state == S_TOP) || (state == S_BOT);
    assign rd_addr       = (state == S_BOT) ? bot_addr : top_addr;

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            row_q <= '0;
            col   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (row_req_valid) begin
                        row_q <= row_req_index;
                        col   <= '0;
                        state <= S_TOP;
                    end
                end
                S_TOP: state <= S_BOT;
                S_BOT: state <= S_CAP;  // Top word returns this cycle
                S_CAP: state <= S_HOLD; // Bottom word returns this cycle
                S_HOLD: begin
                    if (pair_ready) begin
                        if (col == COL_W'(`LM_WIDTH - 1)) begin
                            state <= S_IDLE;
                        end else begin
                            col   <= col + 1'b1;
                            state <= S_TOP;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Pair stays put while held
    always_ff @(posedge clk_root) begin
        if (state == S_BOT) begin
            pair.top <= rd_data;
        end
        if (state == S_CAP) begin
            pair.bottom <= rd_data;
        end
    end

endmodule

// ==== hw/pixel_split.sv ====
`include "led_matrix_macros.svh"

module pixel_split (
    input  led_matrix_pkg::rgb565_t pixel,
    input  logic [2:0]              plane,
    input  logic [2:0]              rgb_enable,
    input  logic [`LM_PLANES-1:0]   plane_enable,
    output logic [2:0]              rgb
);
    logic [5:0] red6;
    logic [5:0] green6;
    logic [5:0] blue6;

    // Red and blue repeat their MSB to reach 6 bits
    assign red6   = {pixel.r, pixel.r[4]};
    assign green6 = pixel.g;
    assign blue6  = {pixel.b, pixel.b[4]};

    assign rgb[0] = red6[plane] & rgb_enable[0] & plane_enable[plane];
    assign rgb[1] = green6[plane] & rgb_enable[1] & plane_enable[plane];
    assign rgb[2] = blue6[plane] & rgb_enable[2] & plane_enable[plane];

endmodule

// ==== hw/matrix_scan.sv ====
`include "led_matrix_macros.svh"

module matrix_scan (
    input  logic                        clk_root,
    input  logic                        rst_n,
    input  led_matrix_pkg::pixel_pair_t pair,
    input  logic                        pair_valid,
    output logic                        pair_ready,
    input  logic                        row_req_ready,
    output logic                        row_req_valid,
    output logic [`LM_ROW_W-1:0]        row_req_index,
    input  logic [2:0]                  rgb_enable,
    input  logic [`LM_PLANES-1:0]       plane_enable,
    output led_matrix_pkg::panel_pins_t pins
);
    import led_matrix_pkg::*;

    localparam int LIT_W = $clog2(`LM_OE_UNIT << (`LM_PLANES - 1)) + 1;
    localparam int ROW_W = `LM_ROW_W;
    localparam int COL_W = `LM_COL_W;

    typedef enum logic [2:0] {S_REQ, S_DATA, S_CLK, S_ADDR, S_LATCH, S_LIT} scan_state_t;

    scan_state_t      state;
    logic [ROW_W-1:0] row;
    logic [2:0]       plane;
    logic [COL_W-1:0] col;
    logic [LIT_W-1:0] lit_cnt;
    logic [2:0]       rgb_top;
    logic [2:0]       rgb_bottom;
    panel_pins_t      pins_q;

    pixel_split split_top (
        .pixel        (pair.top),
        .plane        (plane),
        .rgb_enable   (rgb_enable),
        .plane_enable (plane_enable),
        .rgb          (rgb_top)
    );

    pixel_split split_bottom (
        .pixel        (pair.bottom),
        .plane        (plane),
        .rgb_enable   (rgb_enable),
        .plane_enable (plane_enable),
        .rgb          (rgb_bottom)
    );

    assign row_req_valid = (state == S_REQ);
    assign row_req_index = row;
    assign pair_ready    = (state == S_DATA);
    assign pins          = pins_q;

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            state   <= S_REQ;
            row     <= '0;
            plane   <= '0;
            col     <= '0;
            lit_cnt <= '0;
            pins_q  <= '{rgb_top: '0, rgb_bottom: '0, row_addr: '0,
                         clk_pixel: 1'b0, row_latch: 1'b0, oe_n: 1'b1};
        end else begin
            pins_q.clk_pixel <= 1'b0; // Both strobes last one cycle
            pins_q.row_latch <= 1'b0;
            case (state)
                S_REQ: begin
                    if (row_req_ready) begin
                        col   <= '0;
                        state <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (pair_valid) begin
                        pins_q.rgb_top    <= rgb_top;
                        pins_q.rgb_bottom <= rgb_bottom;
                        state             <= S_CLK;
                    end
                end
                S_CLK: begin
                    pins_q.clk_pixel <= 1'b1; // Data has been stable a cycle
                    if (col == COL_W'(`LM_WIDTH - 1)) begin
                        state <= S_ADDR;
                    end else begin
                        col   <= col + 1'b1;
                        state <= S_DATA;
                    end
                end
                S_ADDR: begin
                    pins_q.oe_n     <= 1'b1;
                    pins_q.row_addr <= row;
                    state           <= S_LATCH;
                end
                S_LATCH: begin
                    pins_q.row_latch <= 1'b1;
                    lit_cnt          <= LIT_W'(`LM_OE_UNIT) << plane; // Plane weight
                    state            <= S_LIT;
                end
                S_LIT: begin
                    if (lit_cnt != '0) begin
                        pins_q.oe_n <= 1'b0;
                        lit_cnt     <= lit_cnt - 1'b1;
                    end else begin
                        // Lit period over, move to next plane or row
                        pins_q.oe_n <= 1'b1;
                        state       <= S_REQ;
                        if (plane == 3'(`LM_PLANES - 1)) begin
                            plane <= '0;
                            if (row == ROW_W'(`LM_HEIGHT / 2 - 1)) begin
                                row <= '0;
                            end else begin
                                row <= row + 1'b1;
                            end
                        end else begin
                            plane <= plane + 1'b1;
                        end
                    end
                end
                default: state <= S_REQ;
            endcase
        end
    end

endmodule

// ==== hw/led_matrix_top.sv ====
`include "led_matrix_macros.svh"

module led_matrix_top (
    input  logic                        clk_root,
    input  logic                        rst_n,
    input  logic                        uart_rx,
    output led_matrix_pkg::panel_pins_t pins
);
    import led_matrix_pkg::*;

    logic [7:0]            rx_byte;
    logic                  rx_valid;
    fb_write_t             wr;
    logic                  wr_valid;
    logic [2:0]            rgb_enable;
    logic [`LM_PLANES-1:0] plane_enable;
    logic [`LM_ADDR_W-1:0] rd_addr;
    logic                  rd_en;
    rgb565_t               rd_data;
    logic                  row_req_valid;
    logic                  row_req_ready;
    logic [`LM_ROW_W-1:0]  row_req_index;
    pixel_pair_t           pair;
    logic                  pair_valid;
    logic                  pair_ready;

    uart_byte_rx u_uart_rx (
        .clk_root (clk_root),
        .rst_n    (rst_n),
        .uart_rx  (uart_rx),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    frame_loader u_loader (
        .clk_root     (clk_root),
        .rst_n        (rst_n),
        .rx_byte      (rx_byte),
        .rx_valid     (rx_valid),
        .wr           (wr),
        .wr_valid     (wr_valid),
        .rgb_enable   (rgb_enable),
        .plane_enable (plane_enable)
    );

    frame_buffer u_fb (
        .clk_root (clk_root),
        .wr       (wr),
        .wr_valid (wr_valid),
        .rd_addr  (rd_addr),
        .rd_en    (rd_en),
        .rd_data  (rd_data)
    );

    framebuffer_fetch u_fetch (
        .clk_root      (clk_root),
        .rst_n         (rst_n),
        .row_req_valid (row_req_valid),
        .row_req_index (row_req_index),
        .row_req_ready (row_req_ready),
        .pair          (pair),
        .pair_valid    (pair_valid),
        .pair_ready    (pair_ready),
        .rd_addr       (rd_addr),
        .rd_en         (rd_en),
        .rd_data       (rd_data)
    );

    matrix_scan u_scan (
        .clk_root      (clk_root),
        .rst_n         (rst_n),
        .pair          (pair),
        .pair_valid    (pair_valid),
        .pair_ready    (pair_ready),
        .row_req_ready (row_req_ready),
        .row_req_valid (row_req_valid),
        .row_req_index (row_req_index),
        .rgb_enable    (rgb_enable),
        .plane_enable  (plane_enable),
        .pins          (pins)
    );

endmodule

// ==== test/tb_led_matrix.sv ====
`include "led_matrix_macros.svh"

module tb_led_matrix;
    import led_matrix_pkg::*;

    localparam int PIXELS  = `LM_WIDTH * `LM_HEIGHT;
    localparam int ROWS    = `LM_HEIGHT / 2;   // Scan rows that each drive both halves
    localparam int TIMEOUT = 20000;            // Cycles allowed for any single wait

    logic        clk_root;
    logic        rst_n;
    logic        uart_rx;
    panel_pins_t pins;

    // Reference state kept by the testbench
    logic [15:0]           model_fb [PIXELS];
    logic [2:0]            model_rgb_en;
    logic [`LM_PLANES-1:0] model_plane_en;

    led_matrix_top dut0 (
        .clk_root (clk_root),
        .rst_n    (rst_n),
        .uart_rx  (uart_rx),
        .pins     (pins)
    );

    always #4 clk_root = ~clk_root;

    task automatic fail_check(input string msg);
        $display("Fail at time %0t: %s", $time, msg);
        $display("=== FAIL ===");
        $fatal(1, "check failed");
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at time %0t while waiting for %s", $time, what);
        $display("=== FAIL ===");
        $fatal(1, "timeout");
    endtask

    // Bit 0 red, bit 1 green, bit 2 blue
    function automatic logic [2:0] expected_rgb(input logic [15:0] px, input int plane);
        logic [5:0] red;
        logic [5:0] green;
        logic [5:0] blue;
        red   = {px[15:11], px[15]};  // Top bit repeated as new low bit
        green = px[10:5];
        blue  = {px[4:0], px[4]};
        expected_rgb[0] = red[plane] & model_rgb_en[0] & model_plane_en[plane];
        expected_rgb[1] = green[plane] & model_rgb_en[1] & model_plane_en[plane];
        expected_rgb[2] = blue[plane] & model_rgb_en[2] & model_plane_en[plane];
    endfunction

    // 8N1 with one idle bit after the stop bit
    task automatic send_byte(input logic [7:0] b);
        logic [10:0] frame;
        frame = {1'b1, 1'b1, b, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(posedge clk_root);
            #1 uart_rx = frame[i];
            repeat (`LM_UART_TICKS - 1) @(posedge clk_root);
        end
    endtask

    task automatic load_random_frame();
        send_byte("L");
        for (int a = 0; a < PIXELS; a++) begin
            model_fb[a] = 16'($urandom);
            send_byte(model_fb[a][7:0]);   // Low byte first
            send_byte(model_fb[a][15:8]);
        end
    endtask

    task automatic set_rgb_enable(input logic [2:0] en);
        send_byte("E");
        send_byte({5'b0, en});
        model_rgb_en = en;
    endtask

    task automatic set_plane_enable(input logic [`LM_PLANES-1:0] en);
        send_byte("M");
        send_byte(8'(en));
        model_plane_en = en;
    endtask

    // Returns the rgb pins at the next single-cycle pixel clock pulse
    task automatic wait_pixel(output logic [2:0] top, output logic [2:0] bottom);
        int n;
        n = 0;
        @(negedge clk_root);
        while (!pins.clk_pixel) begin
            assert (!pins.row_latch) else fail_check("latch before all columns were shifted");
            n++;
            if (n > TIMEOUT) report_timeout("a pixel clock pulse");
            @(negedge clk_root);
        end
        assert (pins.oe_n) else fail_check("oe_n low while shifting");
        top    = pins.rgb_top;
        bottom = pins.rgb_bottom;
    endtask

    // want_row below zero accepts any row
    task automatic wait_latch(input int want_row, input bit strict);
        int n;
        n = 0;
        @(negedge clk_root);
        while (!(pins.row_latch && (want_row < 0 || int'(pins.row_addr) == want_row))) begin
            if (strict) begin
                assert (!pins.clk_pixel) else fail_check("extra pixel clock after last column");
            end
            n++;
            if (n > TIMEOUT) report_timeout("a row latch");
            @(negedge clk_root);
        end
    endtask

    // Counts oe_n low cycles right after a latch
    task automatic check_lit_time(input int plane);
        int lit;
        lit = 0;
        @(negedge clk_root);
        while (!pins.oe_n) begin
            lit++;
            if (lit > TIMEOUT) report_timeout("the end of a lit period");
            @(negedge clk_root);
        end
        assert (lit == (`LM_OE_UNIT << plane)) else fail_check($sformatf(
            "plane %0d lit for %0d cycles, expected %0d", plane, lit, `LM_OE_UNIT << plane));
    endtask

    // Ends just after the latch of the last row and plane
    task automatic sync_to_frame();
        wait_latch(0, 1'b0);
        wait_latch(ROWS - 1, 1'b0);       // First plane of the last row
        for (int p = 1; p < `LM_PLANES; p++) begin
            wait_latch(-1, 1'b0);
        end
    endtask

    task automatic check_frame();
        logic [2:0] top;
        logic [2:0] bot;
        logic [2:0] exp_top;
        logic [2:0] exp_bot;
        sync_to_frame();
        for (int r = 0; r < ROWS; r++) begin
            for (int p = 0; p < `LM_PLANES; p++) begin
                for (int c = 0; c < `LM_WIDTH; c++) begin
                    wait_pixel(top, bot);
                    exp_top = expected_rgb(model_fb[r * `LM_WIDTH + c], p);
                    exp_bot = expected_rgb(model_fb[(r + ROWS) * `LM_WIDTH + c], p);
                    assert (top == exp_top) else fail_check($sformatf(
                        "row %0d plane %0d col %0d top %b, expected %b", r, p, c, top, exp_top));
                    assert (bot == exp_bot) else fail_check($sformatf(
                        "row %0d plane %0d col %0d bottom %b, expected %b", r, p, c, bot, exp_bot));
                end
                wait_latch(-1, 1'b1);
                assert (int'(pins.row_addr) == r) else fail_check($sformatf(
                    "latch row_addr %0d, expected %0d", pins.row_addr, r));
                check_lit_time(p);
            end
        end
    endtask

    task automatic check_reset_state();
        int pulses;
        int n;
        rst_n = 1'b0;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk_root);
            assert (pins.oe_n && !pins.clk_pixel && !pins.row_latch)
                else fail_check("panel pins not idle during reset");
        end
        @(posedge clk_root);
        #1 rst_n = 1'b1;
        pulses = 0;
        n      = 0;
        @(negedge clk_root);
        while (!pins.row_latch) begin
            assert (pins.oe_n) else fail_check("oe_n low before the first latch");
            if (pins.clk_pixel) pulses++;
            n++;
            if (n > TIMEOUT) report_timeout("the first row latch");
            @(negedge clk_root);
        end
        assert (pulses == `LM_WIDTH)
            else fail_check($sformatf("%0d pixel clocks before first latch", pulses));
        assert (pins.row_addr == '0) else fail_check("first latch not on row 0");
    endtask

    task automatic check_random_frame();
        load_random_frame();
        check_frame();
    endtask

    task automatic check_green_only();
        set_rgb_enable(3'b010);
        check_frame();
    endtask

    task automatic check_plane_mask();
        set_rgb_enable(3'b111);
        set_plane_enable(6'b101000);      // Planes 3 and 5 only
        check_frame();
    endtask

    task automatic check_reload_after_unknown();
        set_plane_enable('1);
        send_byte("Q");                   // Not a command
        load_random_frame();
        check_frame();
    endtask

    initial begin
        clk_root       = 1'b0;
        rst_n          = 1'b0;
        uart_rx        = 1'b1;        // Serial line idles high
        model_rgb_en   = 3'b111;
        model_plane_en = '1;
        for (int a = 0; a < PIXELS; a++) begin
            model_fb[a] = '0;
        end
        void'($urandom(9));
        check_reset_state();
        check_random_frame();
        check_green_only();
        check_plane_mask();
        check_reload_after_unknown();
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+hw
hw/led_matrix_pkg.sv
hw/uart_byte_rx.sv
hw/frame_loader.sv
hw/frame_buffer.sv
hw/framebuffer_fetch.sv
hw/pixel_split.sv
hw/matrix_scan.sv
hw/led_matrix_top.sv
test/tb_led_matrix.sv
